// File: Makefile
VERILATOR := verilator
VFLAGS    := --timing --assert -Wno-fatal
TOP       := tb_unaligned_mem
FILELIST  := unaligned_mem.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TB PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/access_sequencer.sv
module access_sequencer import unaligned_mem_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    // requester side
    input  logic                      cmd_start,
    input  logic                      cmd_write,
    output logic                      cmd_ready,
    input  logic [data_width-1:0]     addr,
    input  logic [data_width-1:0]     wdata,
    input  logic [data_width-1:0]     wmask,
    output logic [data_width-1:0]     rdata,
    output logic                      rdata_valid,
    // word memory port
    mem_if.sequencer                  mem,
    // to and from the aligner and merger
    output logic [byte_off_width-1:0] offset,
    output logic [data_width-1:0]     wdata_saved,
    output logic [data_width-1:0]     wmask_saved,
    output logic [data_width-1:0]     word_first,
    output logic [data_width-1:0]     word_second,
    input  logic [data_width-1:0]     read_word,
    input  logic [data_width-1:0]     merged_low,
    input  logic [data_width-1:0]     merged_high
);

    seq_state_t state;
    seq_state_t state_next;
    logic       cmd_write_q;
    word_addr_t addr_q;
    logic [data_width-1:0] second_q;
    word_addr_t base_addr;
    word_addr_t next_addr;
    logic       aligned;
    logic       full_path;
    logic       take_cmd;

    assign offset    = addr_q.split.offset;
    assign aligned   = addr_q.split.offset == '0;
    // single blind write, no read before it
    assign full_path = cmd_write_q && aligned && wmask_saved == full_mask;
    assign cmd_ready = state == idle;
    assign take_cmd  = cmd_ready && cmd_start;

    // aligned address of the word holding the first byte, and the one after
    always_comb begin
        base_addr.split.index  = addr_q.split.index;
        base_addr.split.offset = '0;
        next_addr.split.index  = addr_q.split.index + 1'b1;
        next_addr.split.offset = '0;
    end

    // writes merge with the stored second word, reads use it live
    assign word_second = cmd_write_q ? second_q : mem.rdata;

    // memory requests, one per issue state
    assign mem.cmd_start = mem.cmd_ready && state inside
        {wait_ready, rd_second, wr_rd_second, wr_low, wr_high};
    assign mem.cmd_write = (state == wait_ready && full_path)
                         || state == wr_low || state == wr_high;
    assign mem.addr  = (state inside {rd_second, wr_rd_second, wr_high}) ? next_addr : base_addr;
    // with a full mask merged_low is just the write data
    assign mem.wdata = (state == wr_high) ? merged_high : merged_low;

    // aligned reads come straight from memory
    assign rdata       = (state == rd_first) ? mem.rdata : read_word;
    assign rdata_valid = mem.rdata_valid
                       && ((state == rd_first && aligned) || state == rd_second);

    always_comb begin
        state_next = state;
        case (state)
            idle:
                if (cmd_start) state_next = wait_ready;
            wait_ready:
                if (mem.cmd_ready) begin
                    if (!cmd_write_q) state_next = rd_first;
                    else if (full_path) state_next = done;
                    else state_next = wr_rd_first;
                end
            rd_first:
                if (mem.rdata_valid) state_next = aligned ? done : rd_second;
            // issue goes out on the first cycle, data comes on the next
            rd_second:
                if (mem.rdata_valid) state_next = done;
            wr_rd_first:
                if (mem.rdata_valid) state_next = aligned ? wr_low : wr_rd_second;
            wr_rd_second:
                if (mem.rdata_valid) state_next = wr_low;
            wr_low:
                if (mem.cmd_ready) state_next = aligned ? done : wr_high;
            wr_high:
                if (mem.cmd_ready) state_next = done;
            default:
                state_next = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= idle;
            cmd_write_q <= 1'b0;
        end else begin
            state <= state_next;
            if (take_cmd) cmd_write_q <= cmd_write;
        end
    end

    // command payload and captured read words
    always_ff @(posedge clk) begin
        if (take_cmd) begin
            addr_q.raw  <= addr;
            wdata_saved <= wdata;
            wmask_saved <= wmask;
        end
        if (mem.rdata_valid && state inside {rd_first, wr_rd_first}) word_first <= mem.rdata;
        if (mem.rdata_valid && state == wr_rd_second) second_q <= mem.rdata;
    end

    // every memory read is answered while the FSM waits in a capturing state
    assert property (@(posedge clk) disable iff (!rst_n)
        mem.cmd_start && !mem.cmd_write |=> mem.rdata_valid
            && state inside {rd_first, rd_second, wr_rd_first, wr_rd_second})
        else $error("access_sequencer: memory read not answered in a read state");

    // read result belongs to a read command, which finishes next cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |=> state == done && !cmd_write_q)
        else $error("access_sequencer: stray rdata_valid");

    // requester waits for cmd_ready
    assert property (@(posedge clk) disable iff (!rst_n) cmd_start |-> cmd_ready)
        else $error("access_sequencer: cmd_start while busy");

endmodule

// File: rtl/mem_if.sv
interface mem_if import unaligned_mem_pkg::*; ();

    // request side, from the sequencer
    logic                  cmd_start;
    logic                  cmd_write;
    // always word aligned
    word_addr_t            addr;
    logic [data_width-1:0] wdata;

    // response side, from the word memory
    logic                  cmd_ready;
    logic [data_width-1:0] rdata;
    logic                  rdata_valid;

    modport sequencer (
        output cmd_start, cmd_write, addr, wdata,
        input  cmd_ready, rdata, rdata_valid
    );

    modport memory (
        input  cmd_start, cmd_write, addr, wdata,
        output cmd_ready, rdata, rdata_valid
    );

endinterface

// File: rtl/read_aligner.sv
module read_aligner import unaligned_mem_pkg::*; (
    input  logic [byte_off_width-1:0] offset,
    input  logic [data_width-1:0]     word_first,
    input  logic [data_width-1:0]     word_second,
    output logic [data_width-1:0]     read_word
);

    // two consecutive words seen as one little-endian byte stream
    logic [2*data_width-1:0] word_pair;
    logic [2*data_width-1:0] pair_shifted;
    logic [byte_off_width+2:0] shift_bits;

    // byte offset turned into a bit count
    assign shift_bits = {offset, 3'b000};

    // second word sits above the first, as in memory order
    assign word_pair = {word_second, word_first};

    // drop the bytes below the requested address
    //   offset 1: {second[7:0],  first[31:8]}
    //   offset 2: {second[15:0], first[31:16]}
    //   offset 3: {second[23:0], first[31:24]}
    // offset 0 leaves the first word as it is
    assign pair_shifted = word_pair >> shift_bits;

    // only the low word is the result
    assign read_word = pair_shifted[data_width-1:0];

endmodule

// File: rtl/unaligned_mem_pkg.sv
package unaligned_mem_pkg;

    // data, mask and address words are all this wide
    localparam int data_width = 32;
    // byte position inside one memory word
    localparam int byte_off_width = 2;
    localparam int word_idx_width = data_width - byte_off_width;

    // mask value that selects every bit of a word
    localparam logic [data_width-1:0] full_mask = '1;

    // byte address, seen either whole or split at the word boundary
    typedef union packed {
        logic [data_width-1:0] raw;
        struct packed {
            logic [word_idx_width-1:0] index;
            logic [byte_off_width-1:0] offset;
        } split;
    } word_addr_t;

    // sequencer states
    typedef enum logic [3:0] {
        // waiting for a requester command
        idle,
        // first memory access goes out here
        wait_ready,
        // one spare cycle before cmd_ready returns
        done,
        // read command, first and second word
        rd_first,
        rd_second,
        // read phase in front of a write
        wr_rd_first,
        wr_rd_second,
        // merged words go back to memory
        wr_low,
        wr_high
    } seq_state_t;

endpackage

// File: rtl/unaligned_mem_top.sv
module unaligned_mem_top import unaligned_mem_pkg::*; #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_start,
    input  logic                  cmd_write,
    output logic                  cmd_ready,
    input  logic [data_width-1:0] addr,
    input  logic [data_width-1:0] wdata,
    input  logic [data_width-1:0] wmask,
    output logic [data_width-1:0] rdata,
    output logic                  rdata_valid
);

    // word port between sequencer and memory
    mem_if mem_bus ();

    // side paths to the aligner and merger
    logic [byte_off_width-1:0] offset;
    logic [data_width-1:0]     wdata_saved;
    logic [data_width-1:0]     wmask_saved;
    logic [data_width-1:0]     word_first;
    logic [data_width-1:0]     word_second;
    logic [data_width-1:0]     read_word;
    logic [data_width-1:0]     merged_low;
    logic [data_width-1:0]     merged_high;

    access_sequencer access_sequencer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_ready   (cmd_ready),
        .addr        (addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .mem         (mem_bus.sequencer),
        .offset      (offset),
        .wdata_saved (wdata_saved),
        .wmask_saved (wmask_saved),
        .word_first  (word_first),
        .word_second (word_second),
        .read_word   (read_word),
        .merged_low  (merged_low),
        .merged_high (merged_high)
    );

    read_aligner read_aligner_i (
        .offset      (offset),
        .word_first  (word_first),
        .word_second (word_second),
        .read_word   (read_word)
    );

    write_merger write_merger_i (
        .offset      (offset),
        .wdata       (wdata_saved),
        .wmask       (wmask_saved),
        .word_first  (word_first),
        .word_second (word_second),
        .merged_low  (merged_low),
        .merged_high (merged_high)
    );

    word_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) word_memory_i (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (mem_bus.memory)
    );

endmodule

// File: rtl/word_memory.sv
module word_memory import unaligned_mem_pkg::*; #(
    parameter int MEM_WORDS = 1024
) (
    input  logic clk,
    input  logic rst_n,
    mem_if.memory mem
);

    localparam int idx_width = $clog2(MEM_WORDS);

    logic [data_width-1:0] mem_array [MEM_WORDS];
    logic [idx_width-1:0]  word_idx;
    logic                  accept;
    logic                  read_accept;

    // command taken when both sides agree
    assign accept      = mem.cmd_start && mem.cmd_ready;
    assign read_accept = accept && !mem.cmd_write;
    // only the low index bits reach the array
    assign word_idx    = mem.addr.split.index[idx_width-1:0];

    // busy only in the cycle that returns read data
    assign mem.cmd_ready = !mem.rdata_valid;

    // array contents and the read strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_array[i] <= '0;
            end
            mem.rdata_valid <= 1'b0;
        end else begin
            // single cycle pulse after each accepted read
            mem.rdata_valid <= read_accept;
            if (accept && mem.cmd_write) begin
                mem_array[word_idx] <= mem.wdata;
            end
        end
    end

    // read data register, one cycle latency
    always_ff @(posedge clk) begin
        if (read_accept) begin
            mem.rdata <= mem_array[word_idx];
        end
    end

    // sequencer must never step past the array
    assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> mem.addr.split.index < MEM_WORDS)
        else $error("word_memory: address 0x%h out of range", mem.addr.raw);

    // low address bits must be clear on the word port
    assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> mem.addr.split.offset == '0)
        else $error("word_memory: unaligned address 0x%h", mem.addr.raw);

endmodule

// File: rtl/write_merger.sv
module write_merger import unaligned_mem_pkg::*; (
    input  logic [byte_off_width-1:0] offset,
    input  logic [data_width-1:0]     wdata,
    input  logic [data_width-1:0]     wmask,
    input  logic [data_width-1:0]     word_first,
    input  logic [data_width-1:0]     word_second,
    output logic [data_width-1:0]     merged_low,
    output logic [data_width-1:0]     merged_high
);

    logic [byte_off_width+2:0] shift_bits;
    // data and mask moved up to their byte lane across two words
    logic [2*data_width-1:0]   data_wide;
    logic [2*data_width-1:0]   mask_wide;
    logic [data_width-1:0]     mask_low;
    logic [data_width-1:0]     mask_high;

    assign shift_bits = {offset, 3'b000};

    // zero extend, then shift by the byte offset
    assign data_wide = {{data_width{1'b0}}, wdata} << shift_bits;
    assign mask_wide = {{data_width{1'b0}}, wmask} << shift_bits;

    // low half covers the bytes at and above the offset
    assign mask_low  = mask_wide[data_width-1:0];
    // high half only holds bytes that spill past the word end
    assign mask_high = mask_wide[2*data_width-1:data_width];

    // masked bits take new data, the rest keep the old word
    assign merged_low  = (word_first & ~mask_low)
                       | (data_wide[data_width-1:0] & mask_low);

    // for offset 0 mask_high is all zero so the second word passes unchanged
    assign merged_high = (word_second & ~mask_high)
                       | (data_wide[2*data_width-1:data_width] & mask_high);

endmodule

// File: testbench/tb_unaligned_mem.sv
module tb_unaligned_mem import unaligned_mem_pkg::*; ();

    // memory depth handed to the DUT
    localparam int mem_words      = 1024;
    // five columns per pattern line
    localparam int fields         = 5;
    localparam int max_patterns   = 64;
    // cycles allowed for any single wait
    localparam int timeout_cycles = 50;

    logic                  clk;
    logic                  rst_n;
    logic                  cmd_start;
    logic                  cmd_write;
    logic                  cmd_ready;
    logic [data_width-1:0] addr;
    logic [data_width-1:0] wdata;
    logic [data_width-1:0] wmask;
    logic [data_width-1:0] rdata;
    logic                  rdata_valid;

    // flat copy of the pattern file, one word per column entry
    logic [data_width-1:0] pattern_mem [max_patterns*fields];

    int error_count;
    int test_count;
    int test_fail_count;
    bit timed_out;

    unaligned_mem_top #(
        .MEM_WORDS (mem_words)
    ) unaligned_mem_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_ready   (cmd_ready),
        .addr        (addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // outputs are sampled at the falling edge, away from the register updates
    task automatic wait_for_ready(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            ok = cmd_ready;
        end
    endtask

    // one cycle strobe, payload held until the next command
    task automatic issue_command(input logic [data_width-1:0] op,
                                 input logic [data_width-1:0] a,
                                 input logic [data_width-1:0] d,
                                 input logic [data_width-1:0] m);
        @(posedge clk);
        cmd_start <= 1'b1;
        cmd_write <= op[0];
        addr      <= a;
        wdata     <= d;
        wmask     <= m;
        @(posedge clk);
        cmd_start <= 1'b0;
    endtask

    // counts rdata_valid pulses until the DUT is idle again
    task automatic collect_response(output int pulses,
                                    output logic [data_width-1:0] data,
                                    output bit ok);
        int cycles;
        cycles = 0;
        pulses = 0;
        data = '0;
        ok = 1'b0;
        while (!ok && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            if (rdata_valid) begin
                pulses++;
                data = rdata;
            end
            ok = cmd_ready;
        end
    endtask

    initial begin
        int                    idx;
        int                    pulses;
        logic [data_width-1:0] op;
        logic [data_width-1:0] a;
        logic [data_width-1:0] d;
        logic [data_width-1:0] m;
        logic [data_width-1:0] expected;
        logic [data_width-1:0] got;
        bit                    ok;
        bit                    test_ok;

        rst_n       = 1'b0;
        cmd_start   = 1'b0;
        cmd_write   = 1'b0;
        addr        = '0;
        wdata       = '0;
        wmask       = '0;
        error_count     = 0;
        test_count      = 0;
        test_fail_count = 0;
        timed_out       = 1'b0;

        // unused entries get an op code above 1, which ends the list
        for (int i = 0; i < max_patterns*fields; i++) begin
            pattern_mem[i] = 32'hf000_0000 | i;
        end
        $readmemh("testbench/unaligned_mem_patterns.txt", pattern_mem);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // idle state straight after reset
        @(negedge clk);
        test_ok = 1'b1;
        assert (cmd_ready === 1'b1 && rdata_valid === 1'b0) else begin
            $display("[ERROR] %0t: after reset cmd_ready=%b rdata_valid=%b",
                     $time, cmd_ready, rdata_valid);
            error_count++;
            test_ok = 1'b0;
        end
        $display("test %0d reset state: %s", test_count, test_ok ? "ok" : "failed");
        if (!test_ok) test_fail_count++;
        test_count++;

        idx = 0;
        while (!timed_out && idx < max_patterns && pattern_mem[idx*fields] <= 1) begin
            op       = pattern_mem[idx*fields];
            a        = pattern_mem[idx*fields+1];
            d        = pattern_mem[idx*fields+2];
            m        = pattern_mem[idx*fields+3];
            expected = pattern_mem[idx*fields+4];
            test_ok  = 1'b1;

            wait_for_ready(ok);
            if (!ok) begin
                $display("timeout: cmd_ready stayed low before test %0d", test_count);
                timed_out = 1'b1;
            end else begin
                issue_command(op, a, d, m);
                collect_response(pulses, got, ok);
                if (!ok) begin
                    $display("timeout: cmd_ready did not return during test %0d", test_count);
                    timed_out = 1'b1;
                end else if (op[0]) begin
                    // a write ends without any read pulse
                    assert (pulses == 0) else begin
                        $display("[ERROR] %0t: test %0d write at 0x%h gave %0d rdata_valid pulses",
                                 $time, test_count, a, pulses);
                        error_count++;
                        test_ok = 1'b0;
                    end
                end else begin
                    assert (pulses == 1) else begin
                        $display("[ERROR] %0t: test %0d read at 0x%h gave %0d rdata_valid pulses",
                                 $time, test_count, a, pulses);
                        error_count++;
                        test_ok = 1'b0;
                    end
                    assert (got == expected) else begin
                        $display("[ERROR] %0t: test %0d read at 0x%h returned 0x%h, expected 0x%h",
                                 $time, test_count, a, got, expected);
                        error_count++;
                        test_ok = 1'b0;
                    end
                end
            end
            if (timed_out) test_ok = 1'b0;
            $display("test %0d %s at 0x%h: %s", test_count, op[0] ? "write" : "read",
                     a, test_ok ? "ok" : "failed");
            if (!test_ok) test_fail_count++;
            test_count++;
            idx++;
        end

        // an empty or unreadable pattern file runs no commands at all
        assert (idx > 0) else begin
            $display("no command patterns were read from the pattern file");
            error_count++;
        end

        $display("tests run: %0d, tests failed: %0d, checks failed: %0d",
                 test_count, test_fail_count, error_count);
        if (error_count == 0 && test_fail_count == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/unaligned_mem_patterns.txt
// columns: op (0 read, 1 write), byte address, write data, write mask, expected read data
// the expected column is ignored for writes
1 00000000 cafebebe ffffffff 00000000
1 00000004 deadbeef ffffffff 00000000
0 00000000 00000000 00000000 cafebebe
0 00000004 00000000 00000000 deadbeef
0 00000001 00000000 00000000 efcafebe
0 00000002 00000000 00000000 beefcafe
0 00000003 00000000 00000000 adbeefca
1 00000008 11223344 ffffffff 00000000
1 00000008 aabbccdd 0000ff00 00000000
0 00000008 00000000 00000000 1122cc44
1 00000008 55555555 f000000f 00000000
0 00000008 00000000 00000000 5122cc45
1 00000010 03020100 ffffffff 00000000
1 00000014 07060504 ffffffff 00000000
1 00000011 aabbccdd ffffffff 00000000
0 00000010 00000000 00000000 bbccdd00
0 00000014 00000000 00000000 070605aa
1 00000012 11223344 ffff00ff 00000000
0 00000010 00000000 00000000 bb44dd00
0 00000014 00000000 00000000 07061122
1 00000013 deadbeef ffffffff 00000000
0 00000010 00000000 00000000 ef44dd00
0 00000014 00000000 00000000 07deadbe
0 00000013 00000000 00000000 deadbeef

// File: unaligned_mem.f
rtl/unaligned_mem_pkg.sv
rtl/mem_if.sv
rtl/word_memory.sv
rtl/read_aligner.sv
rtl/write_merger.sv
rtl/access_sequencer.sv
rtl/unaligned_mem_top.sv
testbench/tb_unaligned_mem.sv
